// File: design/line_bank.sv
//--------------------------------------------------------------------------
// row storage for one row parity, one write port, two registered reads
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module line_bank #(
    parameter int COL_BITS  = 10,
    parameter int SLOT_BITS = 2,
    parameter int DATA_W    = 24
) (
    input  logic                          clk_in2,
    input  logic                          we,
    input  logic [SLOT_BITS+COL_BITS-1:0] waddr,
    input  logic [DATA_W-1:0]             wdata,
    input  logic [SLOT_BITS+COL_BITS-1:0] raddr_a,
    output logic [DATA_W-1:0]             rdata_a,
    input  logic [SLOT_BITS+COL_BITS-1:0] raddr_b,
    output logic [DATA_W-1:0]             rdata_b
);
    localparam int DEPTH = 1 << (SLOT_BITS + COL_BITS);

    logic [DATA_W-1:0] mem [0:DEPTH-1];         // slot-major, column-minor

    always_ff @(posedge clk_in2)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata_a <= mem[raddr_a];
        rdata_b <= mem[raddr_b];
    end

endmodule

// File: design/nearest_scaler_top.sv
//--------------------------------------------------------------------------
// nearest-neighbour upscaler top: tracker, sequencer, fetch, pick
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module nearest_scaler_top #(
    parameter int COL_BITS  = 10,
    parameter int SLOT_BITS = 2
) (
    input  logic                        clk_in2,
    input  logic                        rst_n,
    input  scaler_geom_pkg::scale_cfg_t cfg,
    input  logic                        in_vsync,
    input  logic                        in_de,
    input  pixel_pkg::rgb_t             in_pix,
    output logic                        out_vsync,
    output logic                        out_de,
    output pixel_pkg::rgb_t             out_pix
);
    import scaler_geom_pkg::*;
    import pixel_pkg::*;

    line_wr_t wr;
    logic     row_done;
    dim_t     row_index;
    coord_t   coord;
    logic     coord_valid;
    logic     frame_vs;
    quad_t    quad;
    logic     right_edge;
    logic     bottom_edge;
    logic     x_half;
    logic     y_half;
    logic     fetch_de;
    logic     fetch_vs;

    source_row_tracker #(
        .COL_BITS  (COL_BITS),
        .SLOT_BITS (SLOT_BITS)
    ) source_row_tracker_inst (
        .clk_in2   (clk_in2),
        .rst_n     (rst_n),
        .in_vsync  (in_vsync),
        .in_de     (in_de),
        .in_pix    (in_pix),
        .wr        (wr),
        .row_done  (row_done),
        .row_index (row_index)
    );

    row_sequencer row_sequencer_inst (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .row_done    (row_done),
        .row_index   (row_index),
        .coord       (coord),
        .coord_valid (coord_valid),
        .frame_vs    (frame_vs)
    );

    neighbor_fetch #(
        .COL_BITS  (COL_BITS),
        .SLOT_BITS (SLOT_BITS)
    ) neighbor_fetch_inst (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .wr          (wr),
        .coord       (coord),
        .coord_valid (coord_valid),
        .frame_vs    (frame_vs),
        .quad        (quad),
        .right_edge  (right_edge),
        .bottom_edge (bottom_edge),
        .x_half      (x_half),
        .y_half      (y_half),
        .de          (fetch_de),
        .vs          (fetch_vs)
    );

    pixel_pick pixel_pick_inst (
        .clk_in2     (clk_in2),
        .rst_n       (rst_n),
        .quad        (quad),
        .right_edge  (right_edge),
        .bottom_edge (bottom_edge),
        .x_half      (x_half),
        .y_half      (y_half),
        .de          (fetch_de),
        .vs          (fetch_vs),
        .out_pix     (out_pix),
        .out_de      (out_de),
        .out_vsync   (out_vsync)
    );

endmodule

// File: design/neighbor_fetch.sv
//--------------------------------------------------------------------------
// coordinate to bank addresses, even/odd bank reads, row reorder into
// the 2x2 quad, edge flags and framing pipelined alongside
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module neighbor_fetch #(
    parameter int COL_BITS  = 10,
    parameter int SLOT_BITS = 2
) (
    input  logic                        clk_in2,
    input  logic                        rst_n,
    input  scaler_geom_pkg::scale_cfg_t cfg,
    input  pixel_pkg::line_wr_t         wr,
    input  scaler_geom_pkg::coord_t     coord,
    input  logic                        coord_valid,
    input  logic                        frame_vs,
    output pixel_pkg::quad_t            quad,
    output logic                        right_edge,
    output logic                        bottom_edge,
    output logic                        x_half,
    output logic                        y_half,
    output logic                        de,
    output logic                        vs
);
    import scaler_geom_pkg::*;
    import pixel_pkg::*;

    localparam int ADDR_W = SLOT_BITS + COL_BITS;
    localparam int DATA_W = $bits(rgb_t);

    typedef struct packed {
        logic right;
        logic bottom;
        logic x_half;
        logic y_half;
        logic odd_top;                          // top row read from odd bank
    } side_t;

    logic [1:4]           de_q;
    logic [1:4]           vs_q;
    side_t                side_q [1:4];
    logic [SLOT_BITS-1:0] top_slot;
    logic [SLOT_BITS-1:0] even_slot;
    logic [COL_BITS-1:0]  col0;
    logic [COL_BITS-1:0]  col1;
    logic [ADDR_W-1:0]    waddr;
    logic [ADDR_W-1:0]    even_ra;
    logic [ADDR_W-1:0]    even_rb;
    logic [ADDR_W-1:0]    odd_ra;
    logic [ADDR_W-1:0]    odd_rb;
    rgb_t                 even_a;
    rgb_t                 even_b;
    rgb_t                 odd_a;
    rgb_t                 odd_b;
    quad_t                quad_q3;
    quad_t                quad_q4;

    //--------------------------------------------------------------------------
    // stage 1: addresses
    //--------------------------------------------------------------------------
    // odd y: bottom row is the next even slot
    assign top_slot  = coord.y_int[SLOT_BITS:1];
    assign even_slot = top_slot + coord.y_int[0];
    assign col0      = coord.x_int[COL_BITS-1:0];
    assign col1      = col0 + 1'b1;             // wraps at the right edge, replaced later

    always_ff @(posedge clk_in2)
    begin
        even_ra   <= {even_slot, col0};
        even_rb   <= {even_slot, col1};
        odd_ra    <= {top_slot, col0};
        odd_rb    <= {top_slot, col1};
        side_q[1] <= '{right:   (coord.x_int == cfg.src_width - 1'b1),
                       bottom:  (coord.y_int == cfg.src_height - 1'b1),
                       x_half:  coord.x_half,
                       y_half:  coord.y_half,
                       odd_top: coord.y_int[0]};
        for (int i = 2; i <= 4; i++)
            side_q[i] <= side_q[i-1];
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            de_q <= '0;
            vs_q <= '0;
        end
        else
        begin
            de_q <= {coord_valid, de_q[1:3]};
            vs_q <= {frame_vs, vs_q[1:3]};
        end
    end

    //--------------------------------------------------------------------------
    // stage 2: bank reads
    //--------------------------------------------------------------------------
    assign waddr = {wr.row_slot[SLOT_BITS-1:0], wr.col[COL_BITS-1:0]};

    line_bank #(
        .COL_BITS  (COL_BITS),
        .SLOT_BITS (SLOT_BITS),
        .DATA_W    (DATA_W)
    ) even_bank_inst (
        .clk_in2 (clk_in2),
        .we      (wr.en & ~wr.bank),
        .waddr   (waddr),
        .wdata   (wr.data),
        .raddr_a (even_ra),
        .rdata_a (even_a),
        .raddr_b (even_rb),
        .rdata_b (even_b)
    );

    line_bank #(
        .COL_BITS  (COL_BITS),
        .SLOT_BITS (SLOT_BITS),
        .DATA_W    (DATA_W)
    ) odd_bank_inst (
        .clk_in2 (clk_in2),
        .we      (wr.en & wr.bank),
        .waddr   (waddr),
        .wdata   (wr.data),
        .raddr_a (odd_ra),
        .rdata_a (odd_a),
        .raddr_b (odd_rb),
        .rdata_b (odd_b)
    );

    // stage 3 reorder by parity, stage 4 output register
    always_ff @(posedge clk_in2)
    begin
        if (side_q[2].odd_top)
            quad_q3 <= '{p00: odd_a, p01: odd_b, p10: even_a, p11: even_b};
        else
            quad_q3 <= '{p00: even_a, p01: even_b, p10: odd_a, p11: odd_b};
        quad_q4 <= quad_q3;
    end

    assign quad        = quad_q4;
    assign right_edge  = side_q[4].right;
    assign bottom_edge = side_q[4].bottom;
    assign x_half      = side_q[4].x_half;
    assign y_half      = side_q[4].y_half;
    assign de          = de_q[4];
    assign vs          = vs_q[4];

    a_frame_start: assert property (@(posedge clk_in2) disable iff (!rst_n)
        coord_valid && coord.frame_start |-> frame_vs && !$past(frame_vs))
        else $error("frame start without rising frame_vs");

    // last dest row still inside the source image
    a_last_row: assert property (@(posedge clk_in2) disable iff (!rst_n)
        coord_valid && coord.last_row |-> coord.y_int < cfg.src_height)
        else $error("last row reads source row %0d", coord.y_int);

endmodule

// File: design/pixel_pick.sv
//--------------------------------------------------------------------------
// border replication and half-bit neighbour select, output register
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module pixel_pick (
    input  logic             clk_in2,
    input  logic             rst_n,
    input  pixel_pkg::quad_t quad,
    input  logic             right_edge,
    input  logic             bottom_edge,
    input  logic             x_half,
    input  logic             y_half,
    input  logic             de,
    input  logic             vs,
    output pixel_pkg::rgb_t  out_pix,
    output logic             out_de,
    output logic             out_vsync
);
    import pixel_pkg::*;

    quad_t rep_q;
    logic  x_half_q;
    logic  y_half_q;
    logic  de_q;
    logic  vs_q;

    // right edge repeats the left column, bottom edge the top row
    always_ff @(posedge clk_in2)
    begin
        rep_q <= quad;
        if (right_edge)
        begin
            rep_q.p01 <= quad.p00;
            rep_q.p11 <= quad.p10;
        end
        if (bottom_edge)
        begin
            rep_q.p10 <= quad.p00;
            rep_q.p11 <= right_edge ? quad.p00 : quad.p01;   // corner -> p00
        end
        x_half_q <= x_half;
        y_half_q <= y_half;
    end

    always_ff @(posedge clk_in2)
    begin
        case ({x_half_q, y_half_q})
            2'b00:   out_pix <= rep_q.p00;
            2'b01:   out_pix <= rep_q.p10;
            2'b10:   out_pix <= rep_q.p01;
            default: out_pix <= rep_q.p11;
        endcase
    end

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            de_q      <= 1'b0;
            vs_q      <= 1'b0;
            out_de    <= 1'b0;
            out_vsync <= 1'b0;
        end
        else
        begin
            de_q      <= de;
            vs_q      <= vs;
            out_de    <= de_q;
            out_vsync <= vs_q;
        end
    end

endmodule

// File: design/pixel_pkg.sv
//--------------------------------------------------------------------------
// pixel types: RGB pixel, 2x2 neighbourhood, line-store write record
//--------------------------------------------------------------------------
package pixel_pkg;

    localparam int CH_W       = 8;
    localparam int MAX_SLOT_W = 4;
    localparam int MAX_COL_W  = 11;

    typedef struct packed {
        logic [CH_W-1:0] r;
        logic [CH_W-1:0] g;
        logic [CH_W-1:0] b;
    } rgb_t;

    // top-left, top-right, bottom-left, bottom-right
    typedef struct packed {
        rgb_t p00;
        rgb_t p01;
        rgb_t p10;
        rgb_t p11;
    } quad_t;

    typedef struct packed {
        logic                  en;
        logic                  bank;            // odd source row
        logic [MAX_SLOT_W-1:0] row_slot;
        logic [MAX_COL_W-1:0]  col;
        rgb_t                  data;
    } line_wr_t;

endpackage

// File: design/row_sequencer.sv
//--------------------------------------------------------------------------
// destination grid walker: row record, x/y accumulators, output framing
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module row_sequencer (
    input  logic                        clk_in2,
    input  logic                        rst_n,
    input  scaler_geom_pkg::scale_cfg_t cfg,
    input  logic                        row_done,
    input  scaler_geom_pkg::dim_t       row_index,
    output scaler_geom_pkg::coord_t     coord,
    output logic                        coord_valid,
    output logic                        frame_vs
);
    import scaler_geom_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ROW_CHECK,
        S_EMIT,
        S_ROW_ADV,
        S_RETIRE
    } state_t;

    state_t     state;
    fixed_pos_u x_pos;
    fixed_pos_u y_pos;
    dim_t       x_cnt;
    dim_t       y_cnt;
    dim_t       done_idx;                       // highest completed source row
    logic       pending;
    logic       last_row;
    logic       last_col;
    dim_t       need_row;
    logic       row_ready;

    assign last_row = (y_cnt == cfg.dst_height - 1'b1);
    assign last_col = (x_cnt == cfg.dst_width - 1'b1);

    // rounded source row plus one, satisfied anyway once the frame is all in
    assign need_row  = y_pos.f.int_part + DIM_W'(y_pos.f.half) + 1'b1;
    assign row_ready = (need_row <= done_idx) || (done_idx == cfg.src_height - 1'b1)
                       || last_row;

    //--------------------------------------------------------------------------
    // FSM and row record
    //--------------------------------------------------------------------------
    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            state     <= S_IDLE;
            pending   <= 1'b0;
            done_idx  <= '0;
            frame_vs  <= 1'b0;
            y_pos.raw <= '0;
            y_cnt     <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (pending)
                    begin
                        state <= S_ROW_CHECK;
                        if (done_idx == '0)     // frame restart
                        begin
                            y_pos.raw <= '0;
                            y_cnt     <= '0;
                        end
                    end
                end
                S_ROW_CHECK:
                begin
                    if ((y_cnt == cfg.dst_height) || !row_ready)
                        state <= S_RETIRE;
                    else
                    begin
                        state <= S_EMIT;
                        if (y_cnt == '0)
                            frame_vs <= 1'b1;
                    end
                end
                S_EMIT:
                begin
                    if (last_col)
                    begin
                        state <= S_ROW_ADV;
                        if (last_row)
                            frame_vs <= 1'b0;
                    end
                end
                S_ROW_ADV:
                begin
                    y_pos.raw <= y_pos.raw + POS_W'(cfg.y_ratio);
                    y_cnt     <= y_cnt + 1'b1;
                    state     <= last_row ? S_RETIRE : S_ROW_CHECK;
                end
                default:
                    state <= S_IDLE;            // S_RETIRE
            endcase

            if (row_done)
            begin
                pending  <= 1'b1;
                done_idx <= row_index;
            end
            else if (state == S_RETIRE)
                pending <= 1'b0;
        end
    end

    // x restarts every row
    always_ff @(posedge clk_in2)
    begin
        if (state == S_EMIT)
        begin
            x_pos.raw <= x_pos.raw + POS_W'(cfg.x_ratio);
            x_cnt     <= x_cnt + 1'b1;
        end
        else
        begin
            x_pos.raw <= '0;
            x_cnt     <= '0;
        end
    end

    assign coord_valid = (state == S_EMIT);
    assign coord = '{x_int:       x_pos.f.int_part,
                     y_int:       y_pos.f.int_part,
                     x_half:      x_pos.f.half,
                     y_half:      y_pos.f.half,
                     frame_start: (x_cnt == '0) && (y_cnt == '0),
                     last_row:    last_row};

    a_x_in_row: assert property (@(posedge clk_in2) disable iff (!rst_n)
        coord_valid |-> x_cnt < cfg.dst_width)
        else $error("coordinate beyond destination width");

    // upstream blanking too short for the output to keep up
    a_no_overrun: assert property (@(posedge clk_in2) disable iff (!rst_n)
        row_done |-> !pending)
        else $error("row %0d completed while a row is still pending", row_index);

endmodule

// File: design/scaler_geom_pkg.sv
//--------------------------------------------------------------------------
// geometry types: image dimensions, scaler configuration,
// fixed-point position word and destination coordinate
//--------------------------------------------------------------------------
package scaler_geom_pkg;

    localparam int DIM_W  = 11;
    localparam int FRAC_W = 16;
    localparam int POS_W  = DIM_W + FRAC_W;     // 27 bit accumulator

    typedef logic [DIM_W-1:0] dim_t;

    typedef struct packed {
        dim_t              src_width;
        dim_t              src_height;
        dim_t              dst_width;
        dim_t              dst_height;
        logic [FRAC_W-1:0] x_ratio;             // source step per dest pixel
        logic [FRAC_W-1:0] y_ratio;
    } scale_cfg_t;

    // stepped as a plain sum, decoded as integer / half / rest
    typedef union packed {
        logic [POS_W-1:0] raw;
        struct packed {
            dim_t              int_part;
            logic              half;
            logic [FRAC_W-2:0] rest;
        } f;
    } fixed_pos_u;

    typedef struct packed {
        dim_t x_int;
        dim_t y_int;
        logic x_half;
        logic y_half;
        logic frame_start;                      // first pixel of dest row 0
        logic last_row;
    } coord_t;

endpackage

// File: design/source_row_tracker.sv
//--------------------------------------------------------------------------
// source side: column and row counting, line-store writes, row completion
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module source_row_tracker #(
    parameter int COL_BITS  = 10,
    parameter int SLOT_BITS = 2
) (
    input  logic                  clk_in2,
    input  logic                  rst_n,
    input  logic                  in_vsync,
    input  logic                  in_de,
    input  pixel_pkg::rgb_t       in_pix,
    output pixel_pkg::line_wr_t   wr,
    output logic                  row_done,
    output scaler_geom_pkg::dim_t row_index
);
    import pixel_pkg::*;
    import scaler_geom_pkg::*;

    logic                  pix_in;
    logic                  de_d;
    logic                  de_fall;
    logic [COL_BITS:0]     col_cnt;             // spare msb catches overflow
    dim_t                  row_cnt;
    logic                  wr_en;
    logic                  wr_bank;
    logic [MAX_SLOT_W-1:0] wr_slot;
    logic [MAX_COL_W-1:0]  wr_col;
    rgb_t                  wr_data;

    assign pix_in  = in_vsync & in_de;
    assign de_fall = de_d & ~pix_in;

    always_ff @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            de_d     <= 1'b0;
            col_cnt  <= '0;
            row_cnt  <= '0;
            wr_en    <= 1'b0;
            row_done <= 1'b0;
        end
        else
        begin
            de_d     <= pix_in;
            wr_en    <= pix_in;
            row_done <= de_fall;
            if (pix_in)
                col_cnt <= col_cnt + 1'b1;
            else
                col_cnt <= '0;
            if (!in_vsync)
                row_cnt <= '0;
            else if (de_fall)
                row_cnt <= row_cnt + 1'b1;
        end
    end

    // row n -> bank n[0], slot n/2
    always_ff @(posedge clk_in2)
    begin
        wr_bank   <= row_cnt[0];
        wr_slot   <= MAX_SLOT_W'(row_cnt[SLOT_BITS:1]);
        wr_col    <= MAX_COL_W'(col_cnt[COL_BITS-1:0]);
        wr_data   <= in_pix;
        row_index <= row_cnt;                   // still the finished row on de fall
    end

    assign wr = '{en: wr_en, bank: wr_bank, row_slot: wr_slot, col: wr_col, data: wr_data};

    a_col_fits: assert property (@(posedge clk_in2) disable iff (!rst_n)
        pix_in |-> !col_cnt[COL_BITS])
        else $error("source row longer than %0d pixels", 1 << COL_BITS);

endmodule

// File: list.f
design/scaler_geom_pkg.sv
design/pixel_pkg.sv
design/line_bank.sv
design/source_row_tracker.sv
design/neighbor_fetch.sv
design/row_sequencer.sv
design/pixel_pick.sv
design/nearest_scaler_top.sv
verification/tb_nearest_scaler.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the scaler testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD=build
LOG="$BUILD/sim.log"
mkdir -p "$BUILD" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_nearest_scaler \
    -Mdir "$BUILD/obj" -f list.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"$BUILD/obj/Vtb_nearest_scaler" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail"
exit 1

// File: verification/tb_nearest_scaler.sv
//--------------------------------------------------------------------------
// testbench for the nearest-neighbour scaler: LFSR source images,
// reference mapping rule, port assertions, watchdog and reporting
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_nearest_scaler;
    import scaler_geom_pkg::*;
    import pixel_pkg::*;

    localparam int MAX_W = 16;
    localparam int MAX_H = 8;

    logic        clk_in2;
    logic        rst_n;
    scale_cfg_t  cfg;
    logic        in_vsync;
    logic        in_de;
    rgb_t        in_pix;
    logic        out_vsync;
    logic        out_de;
    rgb_t        out_pix;

    rgb_t        image [0:MAX_H-1][0:MAX_W-1];
    logic [31:0] lfsr;
    int          src_w;
    int          src_h;
    int          dst_w;
    int          dst_h;
    int          x_ratio;
    int          y_ratio;
    int          run_len;                       // pixels so far in this output row
    int          rows_done;                     // finished output rows in this frame
    int          frames_seen;
    int          pix_seen;
    logic        vs_d;
    logic        quiet;
    int          ref_row;
    int          ref_col;
    rgb_t        exp_pix;
    int          pix_errors   = 0;
    int          frame_errors = 0;
    int          idle_errors  = 0;
    int          count_errors = 0;
    int          tests_failed = 0;

    initial clk_in2 = 1'b0;
    always #20 clk_in2 = ~clk_in2;

    nearest_scaler_top #(
        .COL_BITS  (10),
        .SLOT_BITS (2)
    ) nearest_scaler_top_inst (
        .clk_in2   (clk_in2),
        .rst_n     (rst_n),
        .cfg       (cfg),
        .in_vsync  (in_vsync),
        .in_de     (in_de),
        .in_pix    (in_pix),
        .out_vsync (out_vsync),
        .out_de    (out_de),
        .out_pix   (out_pix)
    );

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // round half up, then clamp to the last source index
    function automatic int nearest_index(input int pos, input int ratio, input int limit);
        int idx;
        idx = (pos * ratio + 32768) >>> 16;
        if (idx >= limit)
            idx = limit - 1;
        if (idx < 0)
            idx = 0;
        return idx;
    endfunction

    function automatic int frame_budget(input int sw, input int sh, input int dw, input int dh);
        return 16 + sh * (sw + 3 * dw) + dh * (dw + 3) + 32;
    endfunction

    function automatic int error_total();
        return pix_errors + frame_errors + idle_errors + count_errors;
    endfunction

    assign ref_row = nearest_index(rows_done, y_ratio, src_h);
    assign ref_col = nearest_index(run_len, x_ratio, src_w);
    assign exp_pix = image[ref_row][ref_col];

    //--------------------------------------------------------------------------
    // output position tracking
    //--------------------------------------------------------------------------
    always @(posedge clk_in2)
    begin
        if (!rst_n)
        begin
            run_len     <= 0;
            rows_done   <= 0;
            frames_seen <= 0;
            pix_seen    <= 0;
            vs_d        <= 1'b0;
        end
        else
        begin
            vs_d <= out_vsync;
            if (vs_d && !out_vsync)
                frames_seen <= frames_seen + 1;
            if (out_de)
            begin
                run_len  <= run_len + 1;
                pix_seen <= pix_seen + 1;
            end
            else if (run_len != 0)
            begin
                rows_done <= rows_done + 1;
                run_len   <= 0;
            end
            else if (!out_vsync)
                rows_done <= 0;                 // between frames
        end
    end

    //--------------------------------------------------------------------------
    // port assertions, sampled mid-cycle
    //--------------------------------------------------------------------------
    a_quiet: assert property (@(negedge clk_in2) disable iff (!rst_n)
        quiet |-> !out_de && !out_vsync)
        else
        begin
            $display("MISMATCH %0t out_de/out_vsync got %b%b expected 00",
                     $time, out_de, out_vsync);
            idle_errors++;
        end

    a_pixel: assert property (@(negedge clk_in2) disable iff (!rst_n)
        out_de |-> out_pix == exp_pix)
        else
        begin
            $display("MISMATCH %0t out_pix got %h expected %h (row %0d col %0d)",
                     $time, out_pix, exp_pix, rows_done, run_len);
            pix_errors++;
        end

    a_de_in_vs: assert property (@(negedge clk_in2) disable iff (!rst_n)
        out_de |-> out_vsync)
        else
        begin
            $display("MISMATCH %0t out_vsync got 0 expected 1 while out_de is high", $time);
            frame_errors++;
        end

    a_row_short: assert property (@(negedge clk_in2) disable iff (!rst_n)
        out_de |-> run_len < dst_w)
        else
        begin
            $display("output row runs past %0d pixels at %0t", dst_w, $time);
            frame_errors++;
        end

    a_row_len: assert property (@(negedge clk_in2) disable iff (!rst_n)
        $past(out_de) && !out_de |-> run_len == dst_w)
        else
        begin
            $display("MISMATCH %0t out_de run length got %0d expected %0d",
                     $time, run_len, dst_w);
            frame_errors++;
        end

    a_vs_rise: assert property (@(negedge clk_in2) disable iff (!rst_n)
        !$past(out_vsync) && out_vsync |-> out_de && rows_done == 0 && run_len == 0)
        else
        begin
            $display("out_vsync rose without the first pixel of a frame at %0t", $time);
            frame_errors++;
        end

    a_vs_fall: assert property (@(negedge clk_in2) disable iff (!rst_n)
        $past(out_vsync) && !out_vsync |-> $past(out_de) && rows_done == dst_h - 1)
        else
        begin
            $display("MISMATCH %0t out_de rows per frame got %0d expected %0d",
                     $time, rows_done + 1, dst_h);
            frame_errors++;
        end

    //--------------------------------------------------------------------------
    // stimulus
    //--------------------------------------------------------------------------
    task automatic random_pixel(output rgb_t p);
        logic [23:0] v;
        v = '0;
        for (int i = 0; i < 24; i++)
        begin
            lfsr = lfsr_next(lfsr);
            v    = {v[22:0], lfsr[0]};
        end
        p = v;
    endtask

    task automatic set_config(input int sw, input int sh, input int dw, input int dh);
        src_w   = sw;
        src_h   = sh;
        dst_w   = dw;
        dst_h   = dh;
        x_ratio = (sw << 16) / dw;
        y_ratio = (sh << 16) / dh;
        cfg = '{src_width:  DIM_W'(sw),
                src_height: DIM_W'(sh),
                dst_width:  DIM_W'(dw),
                dst_height: DIM_W'(dh),
                x_ratio:    FRAC_W'(x_ratio),
                y_ratio:    FRAC_W'(y_ratio)};
    endtask

    // new image, then rows with 3*dst_w blanking; waits for the output frame
    task automatic send_frame;
        int   target;
        rgb_t p;
        target = frames_seen + 1;
        for (int r = 0; r < src_h; r++)
            for (int c = 0; c < src_w; c++)
            begin
                random_pixel(p);
                image[r][c] = p;
            end
        in_vsync = 1'b1;
        repeat (4) @(negedge clk_in2);
        for (int r = 0; r < src_h; r++)
        begin
            for (int c = 0; c < src_w; c++)
            begin
                in_de  = 1'b1;
                in_pix = image[r][c];
                @(negedge clk_in2);
            end
            in_de  = 1'b0;
            in_pix = '0;
            repeat (3 * dst_w) @(negedge clk_in2);
        end
        in_vsync = 1'b0;
        wait (frames_seen == target);
        repeat (8) @(negedge clk_in2);
    endtask

    task automatic report_test(input int num, input string name, input int err_before,
                               input int pix_before, input int pix_expected);
        int errs;
        a_pix_count: assert (pix_seen - pix_before == pix_expected)
            else
            begin
                $display("MISMATCH %0t out_de pixel count got %0d expected %0d",
                         $time, pix_seen - pix_before, pix_expected);
                count_errors++;
            end
        errs = error_total() - err_before;
        if (errs == 0)
            $display("test %0d %s: passed, %0d pixels", num, name, pix_seen - pix_before);
        else
        begin
            $display("test %0d %s: failed with %0d errors", num, name, errs);
            tests_failed++;
        end
    endtask

    initial
    begin
        int errs0;
        int pix0;
        rst_n    = 1'b0;
        in_vsync = 1'b0;
        in_de    = 1'b0;
        in_pix   = '0;
        quiet    = 1'b0;
        lfsr     = 32'd78890;
        set_config(8, 6, 16, 12);
        repeat (2) @(negedge clk_in2);
        rst_n = 1'b1;

        quiet = 1'b1;
        errs0 = error_total();
        pix0  = pix_seen;
        repeat (20) @(negedge clk_in2);
        quiet = 1'b0;
        report_test(1, "quiet after reset", errs0, pix0, 0);

        errs0 = error_total();
        pix0  = pix_seen;
        send_frame();
        report_test(2, "2x upscale 8x6 to 16x12", errs0, pix0, 16 * 12);

        set_config(10, 7, 17, 11);
        errs0 = error_total();
        pix0  = pix_seen;
        send_frame();
        report_test(3, "upscale 10x7 to 17x11", errs0, pix0, 17 * 11);

        // framing errors and pixels of all frames so far count here
        errs0 = error_total() - frame_errors;
        a_two_frames: assert (frames_seen == 2)
            else
            begin
                $display("MISMATCH %0t frames_seen got %0d expected 2", $time, frames_seen);
                count_errors++;
            end
        report_test(4, "frame shape", errs0, 0, 16 * 12 + 17 * 11);

        set_config(8, 6, 16, 12);
        errs0 = error_total();
        pix0  = pix_seen;
        send_frame();
        send_frame();
        report_test(5, "two frames back to back", errs0, pix0, 2 * 16 * 12);

        $display("summary: 5 tests, %0d failed, %0d pixels, %0d pixel, %0d framing, %0d other",
                 tests_failed, pix_seen, pix_errors, frame_errors, idle_errors + count_errors);
        if (tests_failed == 0 && error_total() == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    // watchdog
    initial
    begin
        int limit;
        limit = 2 * (40 + 3 * frame_budget(8, 6, 16, 12) + frame_budget(10, 7, 17, 11));
        repeat (limit) @(posedge clk_in2);
        $display("watchdog: run did not finish within %0d cycles", limit);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
